//--- sim.f
+incdir+sim
common/aes_types_pkg.sv
common/aes_func_pkg.sv
key_schedule/key_expander.sv
key_schedule/round_key_store.sv
cipher/round_engine.sv
source/aes_core.sv
sim/tb_aes_core.sv

//--- Bender.yml
package:
  name: aes_core

dependencies: {}

sources:
  # shared packages, types before functions
  - common/aes_types_pkg.sv
  - common/aes_func_pkg.sv
  # key schedule
  - key_schedule/key_expander.sv
  - key_schedule/round_key_store.sv
  # cipher datapath
  - cipher/round_engine.sv
  # top level
  - source/aes_core.sv
  # testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_aes_core.sv

//--- sim/aes_tb_vectors.svh
/* Known-answer keys, plaintexts and ciphertexts for the AES-128 testbench.
   Included inside the testbench module, entry n of each table forms one vector. */

`ifndef AES_TB_VECTORS_SVH
`define AES_TB_VECTORS_SVH

localparam int num_vectors = 3;

// FIPS-197 example, FIPS-197 appendix B, textbook example key
localparam logic [0:num_vectors-1][127:0] kat_key = {
  128'h000102030405060708090a0b0c0d0e0f,
  128'h2b7e151628aed2a6abf7158809cf4f3c,
  128'h0f1571c947d9e8590cb7add6af7f6798
};

localparam logic [0:num_vectors-1][127:0] kat_plain = {
  128'h00112233445566778899aabbccddeeff,
  128'h3243f6a8885a308d313198a2e0370734,
  128'h0123456789abcdeffedcba9876543210
};

localparam logic [0:num_vectors-1][127:0] kat_cipher = {
  128'h69c4e0d86a7b0430d8cdb78070b4c55a,
  128'h3925841d02dc09fbdc118597196a0b32,
  128'hff0b844a0853bf7c6934ab4364148fb9
};

`endif

//--- sim/tb_aes_core.sv
/* Directed testbench for the iterative AES-128 core: key timing, known answers,
   back-to-back blocks, ignored strobes and re-keying, with a closing error count. */

`default_nettype none

module tb_aes_core
  import aes_types_pkg::*;
();

  `include "aes_tb_vectors.svh"

  localparam int clk_period  = 40;
  localparam int drive_delay = 5;
  localparam int reset_len   = 4;
  localparam int key_delay   = 11;
  localparam int block_delay = 11;
  localparam int wait_limit  = 20;

  // cycle budget: reset, 7 key loads, 7 blocks, 2 gaps, the busy loop, margin
  localparam int run_cycles = reset_len + 8 + 7 * (key_delay + 1) + 7 * (block_delay + 2)
                              + 2 * 7 + 17 + 50;

  logic                   clk;
  logic                   rst_n;
  logic                   key_valid;
  logic [block_width-1:0] key;
  logic                   key_ready;
  logic                   block_valid;
  logic [block_width-1:0] block_in;
  logic                   busy;
  logic                   cipher_valid;
  logic [block_width-1:0] cipher_out;

  int          error_count = 0;
  int          check_count = 0;
  logic [15:0] lfsr_state  = 16'd9;

  aes_core i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .key_valid    (key_valid),
    .key          (key),
    .key_ready    (key_ready),
    .block_valid  (block_valid),
    .block_in     (block_in),
    .busy         (busy),
    .cipher_valid (cipher_valid),
    .cipher_out   (cipher_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // inputs change and outputs are sampled a little after the rising edge
  task automatic tick;
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic expect_block(input string name, input logic [block_width-1:0] exp,
                              input logic [block_width-1:0] act);
    check_count++;
    assert (act === exp)
    else
    begin
      error_count++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic verify_cycles(input string name, input int exp, input int act);
    check_count++;
    assert (act == exp)
    else
    begin
      error_count++;
      $display("Fail %s: expected %0d cycles, actual %0d", name, exp, act);
    end
  endtask

  task automatic require(input logic cond, input string what);
    check_count++;
    assert (cond === 1'b1)
    else
    begin
      error_count++;
      $display("Error: %s", what);
    end
  endtask

  // 16-bit Galois LFSR, one step per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 3; b++)
    begin
      gap = gap | (int'(lfsr_state[0]) << b);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_key(input string name, input logic [block_width-1:0] new_key);
    int cycles;
    cycles    = 0;
    key       = new_key;
    key_valid = 1'b1;
    tick;
    key_valid = 1'b0;
    require(!key_ready, "key_ready did not drop when the key was accepted");
    while (!key_ready && cycles < wait_limit)
    begin
      tick;
      cycles++;
    end
    require(key_ready, "key_ready never rose after the key load");
    verify_cycles({name, " key_ready delay"}, key_delay, cycles);
  endtask

  task automatic encrypt_block(input string name, input logic [block_width-1:0] block,
                               input logic [block_width-1:0] expected);
    int cycles;
    cycles      = 0;
    block_in    = block;
    block_valid = 1'b1;
    tick;
    block_valid = 1'b0;
    require(busy, "block was not accepted, busy stayed low");
    while (!cipher_valid && cycles < wait_limit)
    begin
      tick;
      cycles++;
    end
    require(cipher_valid, "cipher_valid never pulsed after the block was accepted");
    verify_cycles({name, " latency"}, block_delay, cycles);
    expect_block(name, expected, cipher_out);
    require(busy, "busy was low in the cipher_valid cycle");
    tick;
    require(!busy && !cipher_valid, "busy or cipher_valid still high after the result");
    expect_block({name, " hold"}, expected, cipher_out);
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  task automatic reset_state_test;
    for (int n = 0; n < 8; n++)
    begin
      require(!key_ready && !busy && !cipher_valid, "a status output is high after reset");
      tick;
    end
  endtask

  task automatic key_timing_test;
    load_key("key timing", kat_key[0]);
    require(!busy, "busy rose during a key load");
  endtask

  task automatic known_answer_test;
    string name;
    for (int v = 0; v < num_vectors; v++)
    begin
      name = $sformatf("known answer %0d", v);
      load_key(name, kat_key[v]);
      encrypt_block(name, kat_plain[v], kat_cipher[v]);
    end
  endtask

  task automatic repeated_blocks_test;
    int gap;
    load_key("repeated blocks", kat_key[1]);
    for (int n = 0; n < 2; n++)
    begin
      draw_gap(gap);
      repeat (gap) tick;
      encrypt_block($sformatf("repeated block %0d", n), kat_plain[1], kat_cipher[1]);
    end
  endtask

  // strobes land mid-run and in the cipher_valid cycle, all while busy is high
  task automatic ignored_strobes_test;
    int pulses;
    pulses = 0;
    load_key("ignored strobes", kat_key[0]);
    block_in    = kat_plain[0];
    block_valid = 1'b1;
    tick;
    block_valid = 1'b0;
    require(busy, "block was not accepted, busy stayed low");
    for (int cyc = 1; cyc <= 16; cyc++)
    begin
      tick;
      block_valid = 1'b0;
      key_valid   = 1'b0;
      require(key_ready, "key_ready fell after a key strobe while busy");
      if (cipher_valid)
      begin
        pulses++;
        verify_cycles("ignored strobes latency", block_delay, cyc);
        expect_block("ignored strobes", kat_cipher[0], cipher_out);
      end
      if (cyc == 2 || cyc == 11)
      begin
        block_in    = kat_plain[1];
        block_valid = 1'b1;
      end
      if (cyc == 5 || cyc == 11)
      begin
        key       = kat_key[1];
        key_valid = 1'b1;
      end
    end
    verify_cycles("ignored strobes pulse count", 1, pulses);
    require(!busy, "busy is still high after the ignored strobes");
    // the stored schedule must still be the original key
    encrypt_block("ignored strobes key kept", kat_plain[0], kat_cipher[0]);
  endtask

  task automatic rekey_test;
    load_key("rekey", kat_key[2]);
    encrypt_block("rekey", kat_plain[2], kat_cipher[2]);
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------
  initial
  begin
    rst_n       = 1'b0;
    key_valid   = 1'b0;
    key         = '0;
    block_valid = 1'b0;
    block_in    = '0;
    repeat (reset_len) tick;
    rst_n = 1'b1;
    reset_state_test;
    key_timing_test;
    known_answer_test;
    repeated_blocks_test;
    ignored_strobes_test;
    rekey_test;
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

  initial
  begin
    #(run_cycles * clk_period);
    $display("Watchdog expired, the tests did not finish within %0d cycles", run_cycles);
    $display("checks: %0d, errors: %0d", check_count, error_count + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/aes_core.sv
/* Top level of the iterative AES-128 encryption core. Joins the key expander,
   the round key store and the round engine; strobes in, strobe and level out. */

`default_nettype none

module aes_core
  import aes_types_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    key_valid,
  input  wire  [block_width-1:0] key,
  output logic                   key_ready,
  input  wire                    block_valid,
  input  wire  [block_width-1:0] block_in,
  output logic                   busy,
  output logic                   cipher_valid,
  output logic [block_width-1:0] cipher_out
);

  // expander to store
  logic                   key_wr_en;
  round_idx_t             key_wr_idx;
  logic [block_width-1:0] key_wr_data;

  // engine to store and back
  round_idx_t             rd_idx;
  logic [block_width-1:0] rd_key;

  key_expander i_key_expander (
    .clk         (clk),
    .rst_n       (rst_n),
    .key_valid   (key_valid),
    .key         (key),
    .busy        (busy),
    .key_wr_en   (key_wr_en),
    .key_wr_idx  (key_wr_idx),
    .key_wr_data (key_wr_data),
    .key_ready   (key_ready)
  );

  round_key_store i_round_key_store (
    .clk         (clk),
    .key_wr_en   (key_wr_en),
    .key_wr_idx  (key_wr_idx),
    .key_wr_data (key_wr_data),
    .rd_idx      (rd_idx),
    .rd_key      (rd_key)
  );

  round_engine i_round_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .block_valid  (block_valid),
    .block_in     (block_in),
    .key_ready    (key_ready),
    .rd_key       (rd_key),
    .rd_idx       (rd_idx),
    .busy         (busy),
    .cipher_valid (cipher_valid),
    .cipher_out   (cipher_out)
  );

endmodule

`default_nettype wire

//--- cipher/round_engine.sv
/* Iterative AES-128 datapath: one cipher round per clock over a single state
   register, with the result registered out and flagged by cipher_valid. */

`default_nettype none

module round_engine
  import aes_types_pkg::*;
  import aes_func_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    block_valid,
  input  wire  [block_width-1:0] block_in,
  input  wire                    key_ready,
  input  wire  [block_width-1:0] rd_key,
  output round_idx_t             rd_idx,
  output logic                   busy,
  output logic                   cipher_valid,
  output logic [block_width-1:0] cipher_out
);

  aes_state_t state_q;
  aes_state_t sub_state;
  aes_state_t shift_state;
  aes_state_t mix_state;
  aes_state_t round_out;
  round_idx_t round_q;
  logic       fin_q;
  logic       accept;
  logic       in_round;

  assign accept   = block_valid && key_ready && !busy;
  assign in_round = busy && (round_q != '0);

  // round 0 is read on the accepting cycle, since round_q idles at zero
  assign rd_idx = round_q;

  // ----------------------------------------------------------------------
  // one round of the cipher
  // ----------------------------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < num_bytes; i++)
    begin
      sub_state.bytes[i] = sbox(state_q.bytes[i]);
    end
    // byte 4c+r sits in row r, column c; row r rotates left by r
    for (int c = 0; c < num_cols; c++)
    begin
      for (int r = 0; r < num_rows; r++)
      begin
        shift_state.bytes[num_rows*c + r] =
          sub_state.bytes[num_rows*((c + r) % num_cols) + r];
      end
    end
    // last round skips MixColumns
    for (int c = 0; c < num_cols; c++)
    begin
      mix_state.cols[c] = (round_q == num_rounds) ? shift_state.cols[c]
                                                   : mix_column(shift_state.cols[c]);
    end
    round_out = mix_state ^ rd_key;
  end

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy         <= 1'b0;
      round_q      <= '0;
      fin_q        <= 1'b0;
      cipher_valid <= 1'b0;
    end
    else
    begin
      cipher_valid <= 1'b0;
      if (accept)
      begin
        busy    <= 1'b1;
        round_q <= round_idx_t'(1);
      end
      else if (in_round)
      begin
        if (round_q == num_rounds)
        begin
          round_q <= '0;
          fin_q   <= 1'b1;
        end
        else
        begin
          round_q <= round_q + 1'b1;
        end
      end
      // output register stage
      if (fin_q)
      begin
        fin_q        <= 1'b0;
        cipher_valid <= 1'b1;
      end
      if (cipher_valid)
      begin
        busy <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // datapath registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      state_q <= block_in ^ rd_key;
    end
    else if (in_round)
    begin
      state_q <= round_out;
    end
    if (fin_q)
    begin
      cipher_out <= state_q;
    end
  end

  a_valid_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cipher_valid) |-> busy)
    else $error("round_engine: cipher_valid raised while idle");

endmodule

`default_nettype wire

//--- key_schedule/round_key_store.sv
/* Register file for the eleven AES-128 round keys. Written by the expander,
   read asynchronously by the round engine through its round index. */

`default_nettype none

module round_key_store
  import aes_types_pkg::*;
(
  input  wire                    clk,
  input  wire                    key_wr_en,
  input  wire round_idx_t        key_wr_idx,
  input  wire  [block_width-1:0] key_wr_data,
  input  wire round_idx_t        rd_idx,
  output logic [block_width-1:0] rd_key
);

  // entry n holds round key n
  logic [block_width-1:0] key_mem [0:num_rounds];

  always_ff @(posedge clk)
  begin
    if (key_wr_en)
    begin
      key_mem[key_wr_idx] <= key_wr_data;
    end
  end

  // combinational read, the engine XORs it in the same cycle
  assign rd_key = key_mem[rd_idx];

  // ----------------------------------------------------------------------
  // index checks on both ports
  // ----------------------------------------------------------------------
  // indices come from the expander and the engine counters
  a_wr_in_range: assert property (@(posedge clk)
    key_wr_en |-> key_wr_idx <= num_rounds)
    else $error("round_key_store: write to entry %0d", key_wr_idx);

  a_rd_in_range: assert property (@(posedge clk)
    not (rd_idx > num_rounds))
    else $error("round_key_store: read of entry %0d", rd_idx);

endmodule

`default_nettype wire

//--- key_schedule/key_expander.sv
/* Expands a loaded AES-128 key into round keys 0 to 10, one write per cycle,
   and raises key_ready once the whole schedule sits in the store. */

`default_nettype none

module key_expander
  import aes_types_pkg::*;
  import aes_func_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    key_valid,
  input  wire  [block_width-1:0] key,
  input  wire                    busy,
  output logic                   key_wr_en,
  output round_idx_t             key_wr_idx,
  output logic [block_width-1:0] key_wr_data,
  output logic                   key_ready
);

  aes_state_t            prev_q;
  aes_state_t            next_key;
  round_idx_t            cnt_q;
  logic                  active_q;
  logic                  settle_q;
  logic                  accept;
  logic [word_width-1:0] rot_word;
  logic [word_width-1:0] sub_word;
  logic [word_width-1:0] temp_word;

  // a new key is taken only while no block is being encrypted
  assign accept = key_valid && !busy;

  // ----------------------------------------------------------------------
  // next round key from the previous one
  // ----------------------------------------------------------------------
  always_comb
  begin
    // RotWord on the last word, bytes 12 to 15
    rot_word = {prev_q.bytes[13], prev_q.bytes[14], prev_q.bytes[15], prev_q.bytes[12]};
    for (int i = 0; i < num_rows; i++)
    begin
      sub_word[byte_width*i +: byte_width] = sbox(rot_word[byte_width*i +: byte_width]);
    end
    temp_word = sub_word ^ {rcon(cnt_q), 24'h000000};
    // chained XOR across the four words
    next_key.cols[0] = prev_q.cols[0] ^ temp_word;
    for (int c = 1; c < num_cols; c++)
    begin
      next_key.cols[c] = prev_q.cols[c] ^ next_key.cols[c-1];
    end
  end

  // key 0 goes straight from the port on the accepting edge
  assign key_wr_en   = accept || active_q;
  assign key_wr_idx  = accept ? round_idx_t'(0) : cnt_q;
  assign key_wr_data = accept ? key : next_key;

  // ----------------------------------------------------------------------
  // sequencing
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      active_q  <= 1'b0;
      settle_q  <= 1'b0;
      key_ready <= 1'b0;
      cnt_q     <= '0;
    end
    else if (accept)
    begin
      active_q  <= 1'b1;
      settle_q  <= 1'b0;
      key_ready <= 1'b0;
      cnt_q     <= round_idx_t'(1);
    end
    else
    begin
      if (active_q)
      begin
        if (cnt_q == num_rounds)
        begin
          active_q <= 1'b0;
          settle_q <= 1'b1;
        end
        else
        begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
      // one spare cycle after key 10 before blocks are let in
      if (settle_q)
      begin
        settle_q  <= 1'b0;
        key_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      prev_q <= key;
    end
    else if (active_q)
    begin
      prev_q <= next_key;
    end
  end

  a_wr_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    key_wr_en |-> key_wr_idx <= num_rounds)
    else $error("key_expander: write index %0d past last round", key_wr_idx);

endmodule

`default_nettype wire

//--- common/aes_func_pkg.sv
/* GF(2^8) arithmetic for AES: S-box lookup, byte doubling, column mixing
   and the key schedule round constants. Called from the expander and the engine. */

`default_nettype none

package aes_func_pkg;

  import aes_types_pkg::*;

  // ----------------------------------------------------------------------
  // forward S-box, row picked by the high nibble, entry by the low nibble
  // ----------------------------------------------------------------------
  localparam logic [0:15][0:15][byte_width-1:0] sbox_table = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [byte_width-1:0] sbox(input logic [byte_width-1:0] b);
    return sbox_table[b[7:4]][b[3:0]];
  endfunction

  // ----------------------------------------------------------------------
  // field arithmetic
  // ----------------------------------------------------------------------
  // multiply by 2, reduce by the AES polynomial when the top bit falls out
  function automatic logic [byte_width-1:0] xtime(input logic [byte_width-1:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // one column times the fixed matrix [2 3 1 1] rotated down each row
  function automatic logic [word_width-1:0] mix_column(input logic [word_width-1:0] col);
    logic [byte_width-1:0] b0;
    logic [byte_width-1:0] b1;
    logic [byte_width-1:0] b2;
    logic [byte_width-1:0] b3;
    logic [byte_width-1:0] r0;
    logic [byte_width-1:0] r1;
    logic [byte_width-1:0] r2;
    logic [byte_width-1:0] r3;
    b0 = col[31:24];
    b1 = col[23:16];
    b2 = col[15:8];
    b3 = col[7:0];
    // 3x is 2x ^ x
    r0 = xtime(b0) ^ xtime(b1) ^ b1 ^ b2 ^ b3;
    r1 = b0 ^ xtime(b1) ^ xtime(b2) ^ b2 ^ b3;
    r2 = b0 ^ b1 ^ xtime(b2) ^ xtime(b3) ^ b3;
    r3 = xtime(b0) ^ b0 ^ b1 ^ b2 ^ xtime(b3);
    return {r0, r1, r2, r3};
  endfunction

  // ----------------------------------------------------------------------
  // key schedule constants
  // ----------------------------------------------------------------------
  // round 0 has no constant, so it and anything past 10 give zero
  function automatic logic [byte_width-1:0] rcon(input round_idx_t rnd);
    logic [byte_width-1:0] rc;
    case (rnd)
      4'd1:    rc = 8'h01;
      4'd2:    rc = 8'h02;
      4'd3:    rc = 8'h04;
      4'd4:    rc = 8'h08;
      4'd5:    rc = 8'h10;
      4'd6:    rc = 8'h20;
      4'd7:    rc = 8'h40;
      4'd8:    rc = 8'h80;
      4'd9:    rc = 8'h1b;
      4'd10:   rc = 8'h36;
      default: rc = 8'h00;
    endcase
    return rc;
  endfunction

endpackage

`default_nettype wire

//--- common/aes_types_pkg.sv
/* Widths, round count and the 128-bit state layout for the AES-128 core.
   Imported by every RTL module that carries a block, a key or a round index. */

`default_nettype none

package aes_types_pkg;

  // ----------------------------------------------------------------------
  // sizes fixed by AES-128
  // ----------------------------------------------------------------------
  localparam int block_width = 128;
  localparam int word_width  = 32;
  localparam int byte_width  = 8;
  localparam int num_bytes   = block_width / byte_width;
  localparam int num_cols    = block_width / word_width;
  localparam int num_rows    = word_width / byte_width;
  localparam int num_rounds  = 10;

  // round number, 0 is the initial key addition
  typedef logic [3:0] round_idx_t;

  // ----------------------------------------------------------------------
  // state word
  // ----------------------------------------------------------------------
  // byte 0 is the most significant byte and bytes fill columns,
  // so column c holds bytes 4c to 4c+3 and column 0 is the top word
  typedef union packed {
    // byte view for SubBytes and ShiftRows
    logic [0:num_bytes-1][byte_width-1:0] bytes;
    // column view for MixColumns and key words
    logic [0:num_cols-1][word_width-1:0]  cols;
  } aes_state_t;

endpackage

`default_nettype wire
